/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	// widths that carry a meaning
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  byte_mask_t;

	localparam word_t RESET_PC = 32'h8000_0000;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam word_t INST_EBREAK = 32'h0010_0073;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} branch_e;

	// encoding follows funct3[1:0] of loads and stores
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;

	typedef enum logic {RUN, HALT} core_state_e;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      a_is_pc;
		logic      b_is_imm;
		branch_e   branch;
		logic      jal;
		logic      jalr;
		logic      load;
		logic      store;
		mem_size_e mem_size;
		logic      load_unsigned;
		wb_sel_e   wb_sel;
		logic      rd_we;
		reg_addr_t rd;
		logic      ebreak;
	} dec_ctrl_t;

	typedef struct packed {
		word_t      addr;
		word_t      wdata;
		byte_mask_t mask;
		logic       we;
		logic       re;
	} dmem_req_t;

endpackage

`default_nettype wire

/* src/rv_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit (
	input  wire              clk,
	input  wire              rst,
	input  wire              taken_i,
	input  rv_pkg::word_t    target_i,
	input  wire              ebreak_i,
	output rv_pkg::word_t    pc_o,
	output logic             halted_o
);

	rv_pkg::core_state_e state;
	rv_pkg::word_t       pc;
	rv_pkg::word_t       pc_next;

	// pc holds once halted and on the ebreak itself
	always_comb begin
		if (state == rv_pkg::HALT || ebreak_i) begin
			pc_next = pc;
		end else if (taken_i) begin
			pc_next = target_i;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc    <= rv_pkg::RESET_PC;
			state <= rv_pkg::RUN;
		end else begin
			pc <= pc_next;
			if (state == rv_pkg::RUN && ebreak_i) begin
				state <= rv_pkg::HALT;
			end
		end
	end

	assign pc_o     = pc;
	assign halted_o = (state == rv_pkg::HALT);

endmodule

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  wire               clk,
	input  wire               rst,
	input  wire               we_i,
	input  rv_pkg::reg_addr_t waddr_i,
	input  rv_pkg::word_t     wdata_i,
	input  rv_pkg::reg_addr_t raddr1_i,
	input  rv_pkg::reg_addr_t raddr2_i,
	output rv_pkg::word_t     rdata1_o,
	output rv_pkg::word_t     rdata2_o
);

	rv_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 reads as zero
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* src/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  rv_pkg::word_t     inst_i,
	output rv_pkg::reg_addr_t raddr1_o,
	output rv_pkg::reg_addr_t raddr2_o,
	output rv_pkg::word_t     imm_o,
	output rv_pkg::dec_ctrl_t ctrl_o,
	output logic              invalid_o
);

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	rv_pkg::word_t     imm_i;
	rv_pkg::word_t     imm_s;
	rv_pkg::word_t     imm_b;
	rv_pkg::word_t     imm_u;
	rv_pkg::word_t     imm_j;
	rv_pkg::dec_ctrl_t ctrl;
	logic              valid;

	// shared by op-imm and op, alt picks sub or sra
	function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  alu_sel = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001:  alu_sel = rv_pkg::ALU_SLL;
			3'b010:  alu_sel = rv_pkg::ALU_SLT;
			3'b011:  alu_sel = rv_pkg::ALU_SLTU;
			3'b100:  alu_sel = rv_pkg::ALU_XOR;
			3'b101:  alu_sel = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110:  alu_sel = rv_pkg::ALU_OR;
			default: alu_sel = rv_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign raddr1_o = inst_i[19:15];
	assign raddr2_o = inst_i[24:20];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		ctrl    = '0;
		ctrl.rd = inst_i[11:7];
		imm_o   = imm_i;
		valid   = 1'b0;
		case (opcode)
			rv_pkg::OPC_LUI: begin
				valid         = 1'b1;
				imm_o         = imm_u;
				ctrl.alu_op   = rv_pkg::ALU_PASS_B;
				ctrl.b_is_imm = 1'b1;
				ctrl.rd_we    = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				valid         = 1'b1;
				imm_o         = imm_u;
				ctrl.a_is_pc  = 1'b1;
				ctrl.b_is_imm = 1'b1;
				ctrl.rd_we    = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				valid       = 1'b1;
				imm_o       = imm_j;
				ctrl.jal    = 1'b1;
				ctrl.wb_sel = rv_pkg::WB_LINK;
				ctrl.rd_we  = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				valid       = (funct3 == 3'b000);
				ctrl.jalr   = 1'b1;
				ctrl.wb_sel = rv_pkg::WB_LINK;
				ctrl.rd_we  = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				valid = 1'b1;
				imm_o = imm_b;
				case (funct3)
					3'b000:  ctrl.branch = rv_pkg::BR_EQ;
					3'b001:  ctrl.branch = rv_pkg::BR_NE;
					3'b100:  ctrl.branch = rv_pkg::BR_LT;
					3'b101:  ctrl.branch = rv_pkg::BR_GE;
					3'b110:  ctrl.branch = rv_pkg::BR_LTU;
					3'b111:  ctrl.branch = rv_pkg::BR_GEU;
					default: valid = 1'b0;
				endcase
			end
			rv_pkg::OPC_LOAD: begin
				// lb lh lw lbu lhu only
				valid = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
				ctrl.load          = 1'b1;
				ctrl.b_is_imm      = 1'b1;
				ctrl.mem_size      = rv_pkg::mem_size_e'(funct3[1:0]);
				ctrl.load_unsigned = funct3[2];
				ctrl.wb_sel        = rv_pkg::WB_LOAD;
				ctrl.rd_we         = 1'b1;
			end
			rv_pkg::OPC_STORE: begin
				valid         = (funct3[2] == 1'b0) && (funct3[1:0] != 2'b11);
				imm_o         = imm_s;
				ctrl.store    = 1'b1;
				ctrl.b_is_imm = 1'b1;
				ctrl.mem_size = rv_pkg::mem_size_e'(funct3[1:0]);
			end
			rv_pkg::OPC_OP_IMM: begin
				// shift immediates also need a legal funct7
				valid = (funct3 == 3'b001) ? (funct7 == 7'h00) :
					(funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;
				ctrl.alu_op   = alu_sel(funct3, funct3 == 3'b101 && inst_i[30]);
				ctrl.b_is_imm = 1'b1;
				ctrl.rd_we    = 1'b1;
			end
			rv_pkg::OPC_OP: begin
				valid = (funct7 == 7'h00) ||
					(funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
				ctrl.alu_op = alu_sel(funct3, inst_i[30]);
				ctrl.rd_we  = 1'b1;
			end
			default: begin
				valid       = (inst_i == rv_pkg::INST_EBREAK);
				ctrl.ebreak = valid;
			end
		endcase
		// unsupported word retires as a no-op
		if (!valid) begin
			ctrl = '0;
		end
	end

	assign ctrl_o    = ctrl;
	assign invalid_o = ~valid;

endmodule

`default_nettype wire

/* src/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  rv_pkg::word_t     pc_i,
	input  rv_pkg::word_t     rs1_i,
	input  rv_pkg::word_t     rs2_i,
	input  rv_pkg::word_t     imm_i,
	input  rv_pkg::dec_ctrl_t ctrl_i,
	output rv_pkg::word_t     alu_result_o,
	output logic              taken_o,
	output rv_pkg::word_t     target_o
);

	rv_pkg::word_t op_a;
	rv_pkg::word_t op_b;
	rv_pkg::word_t jalr_sum;
	logic [4:0]    shamt;
	logic          br_cond;

	assign op_a  = ctrl_i.a_is_pc ? pc_i : rs1_i;
	assign op_b  = ctrl_i.b_is_imm ? imm_i : rs2_i;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ctrl_i.alu_op)
			rv_pkg::ALU_ADD:    alu_result_o = op_a + op_b;
			rv_pkg::ALU_SUB:    alu_result_o = op_a - op_b;
			rv_pkg::ALU_SLL:    alu_result_o = op_a << shamt;
			rv_pkg::ALU_SLT:    alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_pkg::ALU_SLTU:   alu_result_o = {31'b0, op_a < op_b};
			rv_pkg::ALU_XOR:    alu_result_o = op_a ^ op_b;
			rv_pkg::ALU_SRL:    alu_result_o = op_a >> shamt;
			rv_pkg::ALU_SRA:    alu_result_o = $unsigned($signed(op_a) >>> shamt);
			rv_pkg::ALU_OR:     alu_result_o = op_a | op_b;
			rv_pkg::ALU_AND:    alu_result_o = op_a & op_b;
			rv_pkg::ALU_PASS_B: alu_result_o = op_b;
			default:            alu_result_o = op_a + op_b;
		endcase
	end

	// branch compare always on the two source registers
	always_comb begin
		case (ctrl_i.branch)
			rv_pkg::BR_EQ:  br_cond = (rs1_i == rs2_i);
			rv_pkg::BR_NE:  br_cond = (rs1_i != rs2_i);
			rv_pkg::BR_LT:  br_cond = ($signed(rs1_i) < $signed(rs2_i));
			rv_pkg::BR_GE:  br_cond = ($signed(rs1_i) >= $signed(rs2_i));
			rv_pkg::BR_LTU: br_cond = (rs1_i < rs2_i);
			rv_pkg::BR_GEU: br_cond = (rs1_i >= rs2_i);
			default:        br_cond = 1'b0;
		endcase
	end

	assign taken_o = br_cond | ctrl_i.jal | ctrl_i.jalr;

	assign jalr_sum = rs1_i + imm_i;

	// jalr drops bit 0 of the sum
	assign target_o = ctrl_i.jalr ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;

endmodule

`default_nettype wire

/* src/rv_mem_align.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_mem_align (
	input  wire               halted_i,
	input  rv_pkg::word_t     alu_result_i,
	input  rv_pkg::word_t     rs2_i,
	input  rv_pkg::word_t     pc_i,
	input  rv_pkg::dec_ctrl_t ctrl_i,
	input  rv_pkg::word_t     dmem_rdata_i,
	output rv_pkg::dmem_req_t dmem_req_o,
	output logic              rd_we_o,
	output rv_pkg::word_t     rd_data_o
);

	logic [1:0]         offset;
	rv_pkg::byte_mask_t mask;
	rv_pkg::word_t      wdata;
	rv_pkg::word_t      load_shifted;
	rv_pkg::word_t      load_data;

	assign offset = alu_result_i[1:0];

	// replicate the data so every lane holds it, the mask picks one
	always_comb begin
		case (ctrl_i.mem_size)
			rv_pkg::MEM_BYTE: begin
				mask  = 4'b0001 << offset;
				wdata = {4{rs2_i[7:0]}};
			end
			rv_pkg::MEM_HALF: begin
				mask  = 4'b0011 << {offset[1], 1'b0};
				wdata = {2{rs2_i[15:0]}};
			end
			default: begin
				mask  = 4'b1111;
				wdata = rs2_i;
			end
		endcase
	end

	assign dmem_req_o.addr  = alu_result_i;
	assign dmem_req_o.wdata = wdata;
	assign dmem_req_o.mask  = mask;
	assign dmem_req_o.we    = ctrl_i.store & ~halted_i;
	assign dmem_req_o.re    = ctrl_i.load & ~halted_i;

	// bring the addressed lane down to bit 0
	assign load_shifted = dmem_rdata_i >> {offset, 3'b000};

	always_comb begin
		case (ctrl_i.mem_size)
			rv_pkg::MEM_BYTE: load_data = ctrl_i.load_unsigned ? {24'b0, load_shifted[7:0]} :
				{{24{load_shifted[7]}}, load_shifted[7:0]};
			rv_pkg::MEM_HALF: load_data = ctrl_i.load_unsigned ? {16'b0, load_shifted[15:0]} :
				{{16{load_shifted[15]}}, load_shifted[15:0]};
			default:          load_data = dmem_rdata_i;
		endcase
	end

	always_comb begin
		case (ctrl_i.wb_sel)
			rv_pkg::WB_LOAD: rd_data_o = load_data;
			rv_pkg::WB_LINK: rd_data_o = pc_i + 32'd4;
			default:         rd_data_o = alu_result_i;
		endcase
	end

	assign rd_we_o = ctrl_i.rd_we & ~halted_i;

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
	input  wire               clk,
	input  wire               rst,
	output rv_pkg::word_t     imem_addr_o,
	input  rv_pkg::word_t     imem_data_i,
	output rv_pkg::dmem_req_t dmem_req_o,
	input  rv_pkg::word_t     dmem_rdata_i,
	output logic              invalid_o,
	output logic              halt_o
);

	rv_pkg::word_t     pc;
	rv_pkg::word_t     rs1_data;
	rv_pkg::word_t     rs2_data;
	rv_pkg::word_t     imm;
	rv_pkg::word_t     alu_result;
	rv_pkg::word_t     target;
	rv_pkg::word_t     rd_data;
	rv_pkg::reg_addr_t raddr1;
	rv_pkg::reg_addr_t raddr2;
	rv_pkg::dec_ctrl_t ctrl;
	logic              taken;
	logic              halted;
	logic              dec_invalid;
	logic              rd_we;
	logic              hold;

	assign imem_addr_o = pc;
	assign halt_o      = halted;
	assign invalid_o   = dec_invalid & rst;

	// no memory or register side effects while in reset or halted
	assign hold = halted | ~rst;

	rv_pc_unit u_pc_unit (
		.clk      (clk),
		.rst      (rst),
		.taken_i  (taken),
		.target_i (target),
		.ebreak_i (ctrl.ebreak),
		.pc_o     (pc),
		.halted_o (halted)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.we_i     (rd_we),
		.waddr_i  (ctrl.rd),
		.wdata_i  (rd_data),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	rv_decoder u_decoder (
		.inst_i    (imem_data_i),
		.raddr1_o  (raddr1),
		.raddr2_o  (raddr2),
		.imm_o     (imm),
		.ctrl_o    (ctrl),
		.invalid_o (dec_invalid)
	);

	rv_execute u_execute (
		.pc_i         (pc),
		.rs1_i        (rs1_data),
		.rs2_i        (rs2_data),
		.imm_i        (imm),
		.ctrl_i       (ctrl),
		.alu_result_o (alu_result),
		.taken_o      (taken),
		.target_o     (target)
	);

	rv_mem_align u_mem_align (
		.halted_i     (hold),
		.alu_result_i (alu_result),
		.rs2_i        (rs2_data),
		.pc_i         (pc),
		.ctrl_i       (ctrl),
		.dmem_rdata_i (dmem_rdata_i),
		.dmem_req_o   (dmem_req_o),
		.rd_we_o      (rd_we),
		.rd_data_o    (rd_data)
	);

endmodule

`default_nettype wire

/* sim/rv_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker (
	input wire               clk,
	input wire               rst,
	input rv_pkg::word_t     pc_i,
	input rv_pkg::dmem_req_t req_i,
	input wire               halt_i
);

	// fetch address must stay on a word boundary
	pc_aligned: assert property (@(posedge clk) disable iff (!rst) pc_i[1:0] == 2'b00)
		else $error("pc not word aligned");

	reset_quiet: assert property (@(posedge clk) !rst |-> (!req_i.we && !req_i.re))
		else $error("memory enable active during reset");

	first_fetch: assert property (@(posedge clk) $rose(rst) |-> pc_i == rv_pkg::RESET_PC)
		else $error("first fetch not at reset pc");

	// halt is sticky and freezes the core
	halt_sticky: assert property (@(posedge clk) disable iff (!rst)
		halt_i |=> (halt_i && $stable(pc_i) && !req_i.we))
		else $error("core left halt or changed state while halted");

endmodule

bind rv_core_top rv_core_checker u_checker (
	.clk    (clk),
	.rst    (rst),
	.pc_i   (imem_addr_o),
	.req_i  (dmem_req_o),
	.halt_i (halt_o)
);

`default_nettype wire

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam rv_pkg::word_t LD_WORD = 32'h80F1_82F3;

	logic              clk;
	logic              rst;
	rv_pkg::word_t     imem_addr;
	rv_pkg::word_t     imem_data;
	rv_pkg::dmem_req_t dmem_req;
	rv_pkg::word_t     dmem_rdata;
	logic              invalid;
	logic              halt;

	rv_pkg::word_t imem [256];
	rv_pkg::word_t dmem [128];
	rv_pkg::word_t init_mem [128];
	rv_pkg::word_t exp_res [64];
	int            res_cat [64];
	int            errs [6];
	string         tname [6] = '{"reset", "alu", "control", "loads", "stores", "invalid_halt"};
	int            n;
	int            k;
	rv_pkg::word_t poison;
	rv_pkg::word_t bad_word;
	rv_pkg::word_t prev_pc;
	rv_pkg::word_t prev_inst;
	logic          prev_halt;
	logic          have_prev;
	int            rst_edges;

	rv_core_top dut (
		.clk          (clk),
		.rst          (rst),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.dmem_req_o   (dmem_req),
		.dmem_rdata_i (dmem_rdata),
		.invalid_o    (invalid),
		.halt_o       (halt)
	);

	// both memories answer in the same cycle
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_req.addr[8:2]];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
		input logic [2:0] f3, input rv_pkg::reg_addr_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
		input rv_pkg::reg_addr_t rs1, input logic [2:0] f3, input rv_pkg::reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
	endfunction

	function automatic rv_pkg::word_t s_type(input logic [11:0] imm, input rv_pkg::reg_addr_t rs2,
		input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
	endfunction

	function automatic rv_pkg::word_t b_type(input logic [12:0] imm, input rv_pkg::reg_addr_t rs2,
		input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
	endfunction

	function automatic rv_pkg::word_t j_type(input logic [20:0] imm, input rv_pkg::reg_addr_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
	endfunction

	// reference load: pick the lane, then extend by size and sign
	function automatic rv_pkg::word_t load_ref(input rv_pkg::word_t w, input logic [2:0] f3,
		input logic [1:0] off);
		rv_pkg::word_t s;
		s = w >> (8 * off);
		case (f3)
			3'b000:  return {{24{s[7]}}, s[7:0]};
			3'b001:  return {{16{s[15]}}, s[15:0]};
			3'b100:  return {24'b0, s[7:0]};
			3'b101:  return {16'b0, s[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic rv_pkg::word_t merge_lanes(input rv_pkg::word_t old, input int lane,
		input int nbytes, input rv_pkg::word_t val);
		rv_pkg::word_t r;
		r = old;
		for (int i = 0; i < nbytes; i++) begin
			r[8*(lane+i) +: 8] = val[8*i +: 8];
		end
		return r;
	endfunction

	function automatic rv_pkg::word_t cur_pc();
		return rv_pkg::RESET_PC + 32'(4 * n);
	endfunction

	task automatic emit(input rv_pkg::word_t w);
		imem[n] = w;
		n++;
	endtask

	// store a register into the next result slot
	task automatic keep(input rv_pkg::reg_addr_t r, input rv_pkg::word_t v, input int c);
		emit(s_type(12'(256 + 4 * k), r, 5'd1, 3'b010));
		exp_res[k] = v;
		res_cat[k] = c;
		k++;
	endtask

	task automatic op_case(input rv_pkg::word_t inst, input rv_pkg::word_t v);
		emit(inst);
		keep(5'd6, v, 1);
	endtask

	// marker is 1 when the branch skips, poison when it falls through
	task automatic br_case(input logic [2:0] f3, input rv_pkg::reg_addr_t rs1,
		input rv_pkg::reg_addr_t rs2, input logic tk);
		emit(i_type(12'd1, 5'd0, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
		emit(b_type(13'd8, rs2, rs1, f3));
		emit(i_type(12'd0, 5'd7, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
		keep(5'd9, tk ? 32'd1 : poison, 2);
	endtask

	task automatic check_eq(input string sig, input rv_pkg::word_t got, input rv_pkg::word_t expv,
		input int c);
		assert (got === expv) else begin
			$display("Error: %s expected %h got %h", sig, expv, got);
			errs[c]++;
		end
	endtask

	task automatic build_program();
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t p;
		a = 32'hFFFF_FFEC;
		b = 32'd7;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013;
		end
		n = 0;
		k = 0;
		emit({20'h00001, 5'd1, rv_pkg::OPC_LUI});
		emit(i_type(12'(-20), 5'd0, 3'b000, 5'd3, rv_pkg::OPC_OP_IMM));
		emit(i_type(12'd7, 5'd0, 3'b000, 5'd4, rv_pkg::OPC_OP_IMM));
		emit({20'hDEAD0, 5'd7, rv_pkg::OPC_LUI});
		emit(i_type(12'h0BE, 5'd7, 3'b000, 5'd7, rv_pkg::OPC_OP_IMM));
		op_case(i_type(12'd100, 5'd3, 3'b000, 5'd6, rv_pkg::OPC_OP_IMM), a + 32'd100);
		op_case(i_type(12'(-5), 5'd3, 3'b010, 5'd6, rv_pkg::OPC_OP_IMM),
			32'($signed(a) < -5));
		op_case(i_type(12'd5, 5'd3, 3'b011, 5'd6, rv_pkg::OPC_OP_IMM), 32'(a < 32'd5));
		op_case(i_type(12'h0F0, 5'd3, 3'b100, 5'd6, rv_pkg::OPC_OP_IMM), a ^ 32'h0F0);
		op_case(i_type(12'hF00, 5'd4, 3'b110, 5'd6, rv_pkg::OPC_OP_IMM), b | 32'hFFFF_FF00);
		op_case(i_type(12'h07F, 5'd3, 3'b111, 5'd6, rv_pkg::OPC_OP_IMM), a & 32'h7F);
		op_case(i_type(12'd3, 5'd3, 3'b001, 5'd6, rv_pkg::OPC_OP_IMM), a << 3);
		op_case(i_type(12'd4, 5'd3, 3'b101, 5'd6, rv_pkg::OPC_OP_IMM), a >> 4);
		op_case(i_type(12'h402, 5'd3, 3'b101, 5'd6, rv_pkg::OPC_OP_IMM),
			32'($signed(a) >>> 2));
		op_case(r_type(7'h00, 5'd4, 5'd3, 3'b000, 5'd6), a + b);
		op_case(r_type(7'h20, 5'd3, 5'd4, 3'b000, 5'd6), b - a);
		op_case(r_type(7'h00, 5'd4, 5'd4, 3'b001, 5'd6), b << 7);
		op_case(r_type(7'h00, 5'd4, 5'd3, 3'b010, 5'd6), 32'($signed(a) < $signed(b)));
		op_case(r_type(7'h00, 5'd4, 5'd3, 3'b011, 5'd6), 32'(a < b));
		op_case(r_type(7'h00, 5'd4, 5'd3, 3'b100, 5'd6), a ^ b);
		op_case(r_type(7'h00, 5'd4, 5'd3, 3'b101, 5'd6), a >> 7);
		op_case(r_type(7'h20, 5'd4, 5'd3, 3'b101, 5'd6), 32'($signed(a) >>> 7));
		op_case(r_type(7'h00, 5'd4, 5'd3, 3'b110, 5'd6), a | b);
		op_case(r_type(7'h00, 5'd4, 5'd3, 3'b111, 5'd6), a & b);
		op_case({20'hABCDE, 5'd6, rv_pkg::OPC_LUI}, 32'hABCD_E000);
		p = cur_pc();
		op_case({20'h00012, 5'd6, rv_pkg::OPC_AUIPC}, p + 32'h0001_2000);
		// x3 is -20 and x4 is 7
		br_case(3'b000, 5'd4, 5'd4, 1'b1);
		br_case(3'b000, 5'd3, 5'd4, 1'b0);
		br_case(3'b001, 5'd3, 5'd4, 1'b1);
		br_case(3'b001, 5'd4, 5'd4, 1'b0);
		br_case(3'b100, 5'd3, 5'd4, 1'b1);
		br_case(3'b100, 5'd4, 5'd3, 1'b0);
		br_case(3'b101, 5'd4, 5'd3, 1'b1);
		br_case(3'b101, 5'd3, 5'd4, 1'b0);
		br_case(3'b110, 5'd4, 5'd3, 1'b1);
		br_case(3'b110, 5'd3, 5'd4, 1'b0);
		br_case(3'b111, 5'd3, 5'd4, 1'b1);
		br_case(3'b111, 5'd4, 5'd3, 1'b0);
		emit(i_type(12'd1, 5'd0, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
		p = cur_pc();
		emit(j_type(21'd8, 5'd10));
		emit(i_type(12'd0, 5'd7, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
		keep(5'd9, 32'd1, 2);
		keep(5'd10, p + 32'd4, 2);
		emit(i_type(12'd1, 5'd0, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
		p = cur_pc();
		emit({20'h00000, 5'd11, rv_pkg::OPC_AUIPC});
		// odd offset, bit 0 of the target is dropped
		emit(i_type(12'd17, 5'd11, 3'b000, 5'd12, rv_pkg::OPC_JALR));
		emit(i_type(12'd0, 5'd7, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
		emit(i_type(12'd0, 5'd7, 3'b000, 5'd9, rv_pkg::OPC_OP_IMM));
		keep(5'd9, 32'd1, 2);
		keep(5'd12, p + 32'd8, 2);
		for (int off = 0; off < 4; off++) begin
			emit(i_type(12'(off), 5'd1, 3'b000, 5'd6, rv_pkg::OPC_LOAD));
			keep(5'd6, load_ref(LD_WORD, 3'b000, 2'(off)), 3);
			emit(i_type(12'(off), 5'd1, 3'b100, 5'd6, rv_pkg::OPC_LOAD));
			keep(5'd6, load_ref(LD_WORD, 3'b100, 2'(off)), 3);
		end
		for (int off = 0; off < 4; off += 2) begin
			emit(i_type(12'(off), 5'd1, 3'b001, 5'd6, rv_pkg::OPC_LOAD));
			keep(5'd6, load_ref(LD_WORD, 3'b001, 2'(off)), 3);
			emit(i_type(12'(off), 5'd1, 3'b101, 5'd6, rv_pkg::OPC_LOAD));
			keep(5'd6, load_ref(LD_WORD, 3'b101, 2'(off)), 3);
		end
		emit(i_type(12'd0, 5'd1, 3'b010, 5'd6, rv_pkg::OPC_LOAD));
		keep(5'd6, LD_WORD, 3);
		for (int lane = 0; lane < 4; lane++) begin
			emit(s_type(12'(16 + 5 * lane), 5'd3, 5'd1, 3'b000));
		end
		emit(s_type(12'h020, 5'd3, 5'd1, 3'b001));
		emit(s_type(12'h026, 5'd3, 5'd1, 3'b001));
		// mul is outside the set, x6 must keep 0x33
		emit(i_type(12'h033, 5'd0, 3'b000, 5'd6, rv_pkg::OPC_OP_IMM));
		bad_word = r_type(7'h01, 5'd4, 5'd3, 3'b000, 5'd6);
		emit(bad_word);
		keep(5'd6, 32'h33, 5);
		emit(rv_pkg::INST_EBREAK);
		emit(s_type(12'h1F0, 5'd7, 5'd1, 3'b010));
	endtask

	always @(posedge clk) begin
		if (dmem_req.we) begin
			for (int l = 0; l < 4; l++) begin
				if (dmem_req.mask[l]) begin
					dmem[dmem_req.addr[8:2]][8*l +: 8] <= dmem_req.wdata[8*l +: 8];
				end
			end
		end
	end

	// per-cycle checks on fetch flow, masks, invalid and halt
	always @(posedge clk) begin
		logic [3:0]    exp_mask;
		logic [1:0]    lane;
		if (!rst) begin
			if (rst_edges > 0) begin
				check_eq("imem_addr_o", imem_addr, rv_pkg::RESET_PC, 0);
				check_eq("dmem_req_o.we", 32'(dmem_req.we), 32'd0, 0);
				check_eq("dmem_req_o.re", 32'(dmem_req.re), 32'd0, 0);
			end
			rst_edges++;
			have_prev <= 1'b0;
		end else begin
			if (!have_prev) begin
				check_eq("imem_addr_o", imem_addr, rv_pkg::RESET_PC, 0);
			end else if (prev_halt || prev_inst == rv_pkg::INST_EBREAK) begin
				check_eq("imem_addr_o", imem_addr, prev_pc, 5);
			end else if (prev_inst[6:0] != rv_pkg::OPC_JAL && prev_inst[6:0] != rv_pkg::OPC_JALR
				&& prev_inst[6:0] != rv_pkg::OPC_BRANCH) begin
				check_eq("imem_addr_o", imem_addr, prev_pc + 32'd4, 0);
			end
			if (!halt) begin
				check_eq("invalid_o", 32'(invalid), 32'(imem_data == bad_word), 5);
				// read enable only on the program's loads
				check_eq("dmem_req_o.re", 32'(dmem_req.re),
					32'(imem_data[6:0] == rv_pkg::OPC_LOAD), 3);
			end
			if (dmem_req.we) begin
				lane = dmem_req.addr[1:0];
				case (imem_data[14:12])
					3'b000:  exp_mask = 4'b0001 << lane;
					3'b001:  exp_mask = 4'b0011 << lane;
					default: exp_mask = 4'b1111;
				endcase
				check_eq("dmem_req_o.mask", 32'(dmem_req.mask), 32'(exp_mask), 4);
				if (halt || imem_data == bad_word) begin
					$display("store issued while halted or on an invalid instruction");
					errs[5]++;
				end
			end
			prev_pc   <= imem_addr;
			prev_inst <= imem_data;
			prev_halt <= halt;
			have_prev <= 1'b1;
		end
	end

	initial begin
		int cyc;
		int passed;
		int failed;
		int total;
		rst       = 1'b0;
		rst_edges = 0;
		void'($urandom(99));
		for (int i = 0; i < 6; i++) begin
			errs[i] = 0;
		end
		for (int i = 0; i < 128; i++) begin
			init_mem[i] = $urandom;
		end
		init_mem[0] = LD_WORD;
		for (int i = 0; i < 128; i++) begin
			dmem[i] <= init_mem[i];
		end
		poison = 32'hDEAD_00BE;
		build_program();
		repeat (16) @(negedge clk);
		rst = 1'b1;
		for (cyc = 0; cyc < 2000 && !halt; cyc++) begin
			@(negedge clk);
		end
		if (!halt) begin
			$display("timeout waiting for the core to halt");
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			// let any late store show up
			for (cyc = 0; cyc < 5; cyc++) begin
				@(negedge clk);
			end
			for (int i = 0; i < k; i++) begin
				check_eq($sformatf("dmem[%0d]", 64 + i), dmem[64 + i], exp_res[i], res_cat[i]);
			end
			for (int l = 0; l < 4; l++) begin
				check_eq($sformatf("dmem[%0d]", 4 + l), dmem[4 + l],
					merge_lanes(init_mem[4 + l], l, 1, 32'hFFFF_FFEC), 4);
			end
			check_eq("dmem[8]", dmem[8], merge_lanes(init_mem[8], 0, 2, 32'hFFFF_FFEC), 4);
			check_eq("dmem[9]", dmem[9], merge_lanes(init_mem[9], 2, 2, 32'hFFFF_FFEC), 4);
			check_eq("dmem[124]", dmem[124], init_mem[124], 5);
			passed = 0;
			failed = 0;
			total  = 0;
			for (int i = 0; i < 6; i++) begin
				$display("test %s: %s (%0d errors)", tname[i], errs[i] == 0 ? "pass" : "fail",
					errs[i]);
				if (errs[i] == 0) begin
					passed++;
				end else begin
					failed++;
				end
				total += errs[i];
			end
			$display("tests passed %0d, failed %0d, errors %0d", passed, failed, total);
			if (failed == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

/* rv_core.f */
src/rv_pkg.sv
src/rv_pc_unit.sv
src/rv_regfile.sv
src/rv_decoder.sv
src/rv_execute.sv
src/rv_mem_align.sv
src/rv_core_top.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_core_tb
FILELIST = rv_core.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	! grep -q "SOME TESTS FAILED" $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
